/* pc_trap_top.f */
design/pc_trap_pkg.sv
design/cpu_state_seq.sv
design/pc_stage.sv
design/trap_csr_regs.sv
design/intr_sources.sv
design/pc_trap_top.sv
tb/tb_clk_gen.sv
tb/pc_trap_tb.sv

/* tb/pc_trap_tb.sv */
`timescale 1ns/100ps

module pc_trap_tb
	import pc_trap_pkg::*;
();

	// row flags
	localparam int F_JMP = 1;
	localparam int F_ECALL = 2;
	localparam int F_EXC = 4;
	localparam int F_MRET = 8;
	localparam int F_SRET = 16;
	// draw stall count and jump target from the lfsr
	localparam int F_RND = 32;
	localparam int F_WR = 64;
	localparam int F_IRQ = 128;
	localparam int F_TMR = 256;

	localparam int DRIVE_DLY = 10;
	localparam int MAX_ROWS = 48;
	localparam int TMR_CMP = 20;
	localparam logic [ADR_W-1:0] START_ADR = 30'h100;
	localparam logic [ADR_W-1:0] MTVEC_ADR = 30'h800;
	localparam logic [ADR_W-1:0] MEPC_ADR = 30'h200;
	localparam logic [ADR_W-1:0] SEPC_ADR = 30'h300;
	localparam logic [ADR_W-1:0] JMP_ADR = 30'h140;
	localparam logic [ADR_W-1:0] JMP_ADR2 = 30'h555;

	// one instruction per row
	typedef struct packed {
		logic [8:0]       flags;
		logic [ADR_W-1:0] jadr;
		logic [1:0]       sel;
		logic [ADR_W-1:0] wdata;
		logic [1:0]       stall;
	} row_t;

	logic             clk;
	logic             rst_n;
	logic             cpu_start;
	logic             stall;
	logic [ADR_W-1:0] cpu_start_adr;
	logic             jmp_condition_ex;
	logic             ecall_condition_ex;
	logic             g_exception;
	logic             cmd_mret_ex;
	logic             cmd_sret_ex;
	logic [ADR_W-1:0] jmp_adr_ex;
	logic             csr_wr;
	logic [1:0]       csr_wr_sel;
	logic [ADR_W-1:0] csr_wr_data;
	logic             ext_irq;
	logic             timer_en;
	logic [FRC_W-1:0] frc_cmp;
	logic [ADR_W-1:0] pc;
	logic [ADR_W-1:0] pc_excep;
	logic             cpu_stat_pc;
	logic [2:0]       cpu_state;
	logic             csr_rmie;
	logic             interrupts_in_pc_state;

	row_t             rows [MAX_ROWS];
	int               n_rows;
	int               row_idx;
	int               cyc;
	int               cyc_limit;
	logic [7:0]       lfsr;
	// reference model
	logic [ADR_W-1:0] m_pc;
	logic [ADR_W-1:0] m_mtvec;
	logic [ADR_W-1:0] m_mepc;
	logic [ADR_W-1:0] m_sepc;
	logic             m_mie;
	logic             m_mpie;
	// pending requests and the first cycle a pc state can take them
	logic             ext_pend;
	int               ext_arm;
	logic             tmr_pend;
	int               tmr_arm;

	tb_clk_gen i_tb_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	pc_trap_top i_pc_trap_top (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.cpu_start              (cpu_start),
		.stall                  (stall),
		.cpu_start_adr          (cpu_start_adr),
		.jmp_condition_ex       (jmp_condition_ex),
		.ecall_condition_ex     (ecall_condition_ex),
		.g_exception            (g_exception),
		.cmd_mret_ex            (cmd_mret_ex),
		.cmd_sret_ex            (cmd_sret_ex),
		.jmp_adr_ex             (jmp_adr_ex),
		.csr_wr                 (csr_wr),
		.csr_wr_sel             (csr_wr_sel),
		.csr_wr_data            (csr_wr_data),
		.ext_irq                (ext_irq),
		.timer_en               (timer_en),
		.frc_cmp                (frc_cmp),
		.pc                     (pc),
		.pc_excep               (pc_excep),
		.cpu_stat_pc            (cpu_stat_pc),
		.cpu_state              (cpu_state),
		.csr_rmie               (csr_rmie),
		.interrupts_in_pc_state (interrupts_in_pc_state)
	);

	// cycle count, also the run limit
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= cyc_limit) begin
			$display("timeout: run still going after %0d cycles", cyc_limit);
			$display(">>> FAIL");
			$fatal(1);
		end
	end

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// one step per bit
	task automatic take_bits(input int n, output logic [31:0] val);
		int k;
		val = '0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic logic has_flag(input logic [8:0] flags, input int f);
		return (flags & f) != 0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error: %s is %h, expected %h", name, got, exp);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	task automatic add_row(input int flags, input logic [ADR_W-1:0] jadr,
			input logic [1:0] sel, input logic [ADR_W-1:0] wdata, input int n_stall);
		rows[n_rows] = {flags[8:0], jadr, sel, wdata, n_stall[1:0]};
		n_rows++;
	endtask

	// return address per the priority of the conditions
	function automatic logic [ADR_W-1:0] excep_of(input logic [8:0] flags,
			input logic [ADR_W-1:0] jadr);
		if (has_flag(flags, F_ECALL)) begin
			return m_pc + ADR_W'(1);
		end else if (has_flag(flags, F_EXC)) begin
			return m_pc;
		end else if (has_flag(flags, F_JMP)) begin
			return jadr;
		end
		return m_pc + ADR_W'(1);
	endfunction

	// a latched request only traps with the enable set
	function automatic logic irq_due(input int c);
		logic due;
		due = (ext_pend && c >= ext_arm) || (tmr_pend && c >= tmr_arm);
		return due && m_mie;
	endfunction

	task automatic model_csr_write(input logic [1:0] sel, input logic [ADR_W-1:0] data);
		case (sel)
			CSR_SEL_MTVEC: m_mtvec = data;
			CSR_SEL_MEPC: m_mepc = data;
			CSR_SEL_SEPC: m_sepc = data;
			default: m_mie = data[0];
		endcase
	endtask

	task automatic model_update(input logic [8:0] flags, input logic [ADR_W-1:0] jadr,
			input int c);
		logic             trap;
		logic [ADR_W-1:0] excep;
		trap = irq_due(c) || has_flag(flags, F_ECALL) || has_flag(flags, F_EXC);
		excep = excep_of(flags, jadr);
		// any pc state clears what it has seen
		if (ext_pend && c >= ext_arm) begin
			ext_pend = 1'b0;
		end
		if (tmr_pend && c >= tmr_arm) begin
			tmr_pend = 1'b0;
		end
		if (trap) begin
			m_mepc = excep;
			m_mpie = m_mie;
			m_mie = 1'b0;
			m_pc = m_mtvec;
		end else if (has_flag(flags, F_MRET)) begin
			m_mie = m_mpie;
			m_pc = m_mepc;
		end else if (has_flag(flags, F_SRET)) begin
			m_pc = m_sepc;
		end else if (has_flag(flags, F_JMP)) begin
			m_pc = jadr;
		end else begin
			m_pc = m_pc + ADR_W'(1);
		end
	endtask

	task automatic wait_pc_state();
		while (!cpu_stat_pc) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
	endtask

	task automatic check_pc_state(input logic [8:0] flags, input logic [ADR_W-1:0] jadr);
		check_value("cpu_state", 32'(cpu_state), 32'(ST_PC));
		check_value("pc", 32'(pc), 32'(m_pc));
		check_value("pc_excep", 32'(pc_excep), 32'(excep_of(flags, jadr)));
		check_value("csr_rmie", 32'(csr_rmie), 32'(m_mie));
		check_value("interrupts_in_pc_state", 32'(interrupts_in_pc_state),
			32'(irq_due(cyc)));
	endtask

	// entered in the if state, left in the if state of the next instruction
	task automatic apply_row(input int idx);
		row_t             r;
		logic [31:0]      bits;
		int               n_stall;
		logic [ADR_W-1:0] jadr;
		r = rows[idx];
		n_stall = r.stall;
		jadr = r.jadr;
		// stall bits first, then the target
		if (has_flag(r.flags, F_RND)) begin
			take_bits(2, bits);
			n_stall = bits;
			if (has_flag(r.flags, F_JMP)) begin
				take_bits(16, bits);
				jadr = ADR_W'(bits);
			end
		end
		jmp_condition_ex = has_flag(r.flags, F_JMP);
		ecall_condition_ex = has_flag(r.flags, F_ECALL);
		g_exception = has_flag(r.flags, F_EXC);
		cmd_mret_ex = has_flag(r.flags, F_MRET);
		cmd_sret_ex = has_flag(r.flags, F_SRET);
		jmp_adr_ex = jadr;
		csr_wr = has_flag(r.flags, F_WR);
		csr_wr_sel = r.sel;
		csr_wr_data = r.wdata;
		ext_irq = has_flag(r.flags, F_IRQ);
		stall = (n_stall > 0);
		if (csr_wr) begin
			model_csr_write(r.sel, r.wdata);
		end
		// sync, edge pulse, latch
		if (ext_irq && m_mie) begin
			ext_pend = 1'b1;
			ext_arm = cyc + 4;
		end
		// counter to compare, compare flop, edge latch
		if (has_flag(r.flags, F_TMR) && !timer_en) begin
			timer_en = 1'b1;
			tmr_pend = 1'b1;
			tmr_arm = cyc + TMR_CMP + 2;
		end
		@(posedge clk);
		#DRIVE_DLY;
		csr_wr = 1'b0;
		ext_irq = 1'b0;
		if (n_stall > 0) begin
			// held in fetch while stalled
			check_value("cpu_state", 32'(cpu_state), 32'(ST_IF));
			repeat (n_stall - 1) begin
				@(posedge clk);
				#DRIVE_DLY;
				check_value("cpu_state", 32'(cpu_state), 32'(ST_IF));
			end
			stall = 1'b0;
		end
		wait_pc_state();
		check_pc_state(r.flags, jadr);
		model_update(r.flags, jadr, cyc);
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic build_table();
		// straight line
		add_row(0, '0, 2'd0, '0, 0);
		add_row(F_RND, '0, 2'd0, '0, 0);
		add_row(0, '0, 2'd0, '0, 2);
		add_row(F_RND, '0, 2'd0, '0, 0);
		// vector and return addresses
		add_row(F_WR, '0, CSR_SEL_MTVEC, MTVEC_ADR, 0);
		add_row(F_WR, '0, CSR_SEL_SEPC, SEPC_ADR, 1);
		add_row(F_WR, '0, CSR_SEL_MEPC, MEPC_ADR, 0);
		// jumps, sret, mret
		add_row(F_JMP, JMP_ADR, 2'd0, '0, 0);
		add_row(F_JMP | F_RND, '0, 2'd0, '0, 0);
		add_row(F_SRET, '0, 2'd0, '0, 0);
		add_row(F_MRET, '0, 2'd0, '0, 1);
		// ecall there and back
		add_row(F_WR, '0, CSR_SEL_MIE, 30'h1, 0);
		add_row(F_ECALL, '0, 2'd0, '0, 0);
		add_row(0, '0, 2'd0, '0, 0);
		add_row(F_MRET, '0, 2'd0, '0, 0);
		// fault keeps its own address
		add_row(F_EXC, '0, 2'd0, '0, 3);
		add_row(F_WR, '0, CSR_SEL_MIE, 30'h1, 0);
		// ecall over jump
		add_row(F_ECALL | F_JMP, JMP_ADR2, 2'd0, '0, 0);
		add_row(F_MRET, '0, 2'd0, '0, 0);
		// external pulse, enabled
		add_row(F_IRQ, '0, 2'd0, '0, 0);
		add_row(0, '0, 2'd0, '0, 0);
		add_row(F_MRET, '0, 2'd0, '0, 0);
		add_row(F_IRQ | F_RND, '0, 2'd0, '0, 0);
		add_row(0, '0, 2'd0, '0, 0);
		add_row(F_MRET, '0, 2'd0, '0, 0);
		// external pulse, disabled
		add_row(F_WR, '0, CSR_SEL_MIE, 30'h0, 0);
		add_row(F_IRQ, '0, 2'd0, '0, 0);
		add_row(F_RND, '0, 2'd0, '0, 0);
		add_row(0, '0, 2'd0, '0, 0);
		// timer compare, one trap only
		add_row(F_WR, '0, CSR_SEL_MIE, 30'h1, 0);
		add_row(F_TMR, '0, 2'd0, '0, 0);
		repeat (6) add_row(0, '0, 2'd0, '0, 0);
		add_row(F_MRET, '0, 2'd0, '0, 0);
		add_row(F_RND, '0, 2'd0, '0, 0);
		add_row(F_JMP | F_RND, '0, 2'd0, '0, 0);
		add_row(0, '0, 2'd0, '0, 0);
	endtask

	initial begin
		cpu_start = 1'b0;
		stall = 1'b0;
		cpu_start_adr = START_ADR;
		jmp_condition_ex = 1'b0;
		ecall_condition_ex = 1'b0;
		g_exception = 1'b0;
		cmd_mret_ex = 1'b0;
		cmd_sret_ex = 1'b0;
		jmp_adr_ex = '0;
		csr_wr = 1'b0;
		csr_wr_sel = 2'd0;
		csr_wr_data = '0;
		ext_irq = 1'b0;
		timer_en = 1'b0;
		frc_cmp = FRC_W'(TMR_CMP);
		lfsr = 8'd66;
		cyc = 0;
		n_rows = 0;
		m_pc = '0;
		m_mtvec = '0;
		m_mepc = '0;
		m_sepc = '0;
		m_mie = 1'b0;
		m_mpie = 1'b0;
		ext_pend = 1'b0;
		ext_arm = 0;
		tmr_pend = 1'b0;
		tmr_arm = 0;
		build_table();
		cyc_limit = n_rows * 12 + 100;
		wait (rst_n === 1'b1);
		// sequencer waits in idle for a start
		check_value("cpu_state", 32'(cpu_state), 32'(ST_IDLE));
		@(posedge clk);
		#DRIVE_DLY;
		cpu_start = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		cpu_start = 1'b0;
		// first pc state loads the start address
		wait_pc_state();
		check_pc_state(9'd0, '0);
		m_pc = START_ADR;
		@(posedge clk);
		#DRIVE_DLY;
		for (row_idx = 0; row_idx < n_rows; row_idx++) begin
			apply_row(row_idx);
		end
		// where the last row went
		wait_pc_state();
		check_value("pc", 32'(pc), 32'(m_pc));
		check_value("csr_rmie", 32'(csr_rmie), 32'(m_mie));
		$display(">>> PASS");
		$finish;
	end

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	// 100 ns period
	localparam int HALF_PERIOD = 50;
	localparam int RST_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// release just after an edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#10 rst_n = 1'b1;
	end

endmodule

/* design/pc_trap_top.sv */
`timescale 1ns/100ps

module pc_trap_top
	import pc_trap_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             cpu_start,
	input  logic             stall,
	input  logic [ADR_W-1:0] cpu_start_adr,
	input  logic             jmp_condition_ex,
	input  logic             ecall_condition_ex,
	input  logic             g_exception,
	input  logic             cmd_mret_ex,
	input  logic             cmd_sret_ex,
	input  logic [ADR_W-1:0] jmp_adr_ex,
	input  logic             csr_wr,
	input  logic [1:0]       csr_wr_sel,
	input  logic [ADR_W-1:0] csr_wr_data,
	input  logic             ext_irq,
	input  logic             timer_en,
	input  logic [FRC_W-1:0] frc_cmp,
	output logic [ADR_W-1:0] pc,
	output logic [ADR_W-1:0] pc_excep,
	output logic             cpu_stat_pc,
	output logic [2:0]       cpu_state,
	output logic             csr_rmie,
	output logic             interrupts_in_pc_state
);

	// trap strobes from pc_stage
	logic             trap_take;
	logic             mret_take;
	// trap registers back to pc_stage
	logic [ADR_W-1:0] csr_mtvec;
	logic [ADR_W-1:0] csr_mepc;
	logic [ADR_W-1:0] csr_sepc;
	// interrupt sources
	logic             g_interrupt;
	logic             g_interrupt_1shot;
	logic             frc_cntr_val_leq;

	cpu_state_seq i_cpu_state_seq (
		.clk         (clk),
		.rst_n       (rst_n),
		.cpu_start   (cpu_start),
		.stall       (stall),
		.cpu_stat_pc (cpu_stat_pc),
		.cpu_state   (cpu_state)
	);

	pc_stage i_pc_stage (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.cpu_start              (cpu_start),
		.stall                  (stall),
		.cpu_stat_pc            (cpu_stat_pc),
		.csr_rmie               (csr_rmie),
		.ecall_condition_ex     (ecall_condition_ex),
		.g_interrupt            (g_interrupt),
		.g_interrupt_1shot      (g_interrupt_1shot),
		.g_exception            (g_exception),
		.frc_cntr_val_leq       (frc_cntr_val_leq),
		.jmp_condition_ex       (jmp_condition_ex),
		.cmd_mret_ex            (cmd_mret_ex),
		.cmd_sret_ex            (cmd_sret_ex),
		.cpu_start_adr          (cpu_start_adr),
		.csr_mtvec_ex           (csr_mtvec),
		.csr_mepc_ex            (csr_mepc),
		.csr_sepc_ex            (csr_sepc),
		.jmp_adr_ex             (jmp_adr_ex),
		.interrupts_in_pc_state (interrupts_in_pc_state),
		.trap_take              (trap_take),
		.mret_take              (mret_take),
		.pc                     (pc),
		.pc_excep               (pc_excep)
	);

	trap_csr_regs i_trap_csr_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.csr_wr      (csr_wr),
		.csr_wr_sel  (csr_wr_sel),
		.csr_wr_data (csr_wr_data),
		.trap_take   (trap_take),
		.mret_take   (mret_take),
		.pc_excep    (pc_excep),
		.csr_mtvec   (csr_mtvec),
		.csr_mepc    (csr_mepc),
		.csr_sepc    (csr_sepc),
		.csr_rmie    (csr_rmie)
	);

	intr_sources i_intr_sources (
		.clk               (clk),
		.rst_n             (rst_n),
		.ext_irq           (ext_irq),
		.timer_en          (timer_en),
		.frc_cmp           (frc_cmp),
		.g_interrupt       (g_interrupt),
		.g_interrupt_1shot (g_interrupt_1shot),
		.frc_cntr_val_leq  (frc_cntr_val_leq)
	);

endmodule

/* design/intr_sources.sv */
`timescale 1ns/100ps

module intr_sources
	import pc_trap_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             ext_irq,
	input  logic             timer_en,
	input  logic [FRC_W-1:0] frc_cmp,
	output logic             g_interrupt,
	output logic             g_interrupt_1shot,
	output logic             frc_cntr_val_leq
);

	// pin synchronizer
	logic             irq_s1;
	logic             irq_s2;
	logic [FRC_W-1:0] frc_cntr;

	// two flops, then level and edge on the third edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_s1 <= 1'b0;
			irq_s2 <= 1'b0;
			g_interrupt <= 1'b0;
			g_interrupt_1shot <= 1'b0;
		end else begin
			irq_s1 <= ext_irq;
			irq_s2 <= irq_s1;
			g_interrupt <= irq_s2;
			// rising edge, one cycle
			g_interrupt_1shot <= irq_s2 & ~g_interrupt;
		end
	end

	// free counter
	// held at zero while disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frc_cntr <= '0;
		end else if (timer_en) begin
			frc_cntr <= frc_cntr + FRC_W'(1);
		end else begin
			frc_cntr <= '0;
		end
	end

	// at or above the compare, only with the timer running
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frc_cntr_val_leq <= 1'b0;
		end else begin
			frc_cntr_val_leq <= timer_en & (frc_cntr >= frc_cmp);
		end
	end

endmodule

/* design/trap_csr_regs.sv */
`timescale 1ns/100ps

module trap_csr_regs
	import pc_trap_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             csr_wr,
	input  logic [1:0]       csr_wr_sel,
	input  logic [ADR_W-1:0] csr_wr_data,
	input  logic             trap_take,
	input  logic             mret_take,
	input  logic [ADR_W-1:0] pc_excep,
	output logic [ADR_W-1:0] csr_mtvec,
	output logic [ADR_W-1:0] csr_mepc,
	output logic [ADR_W-1:0] csr_sepc,
	output logic             csr_rmie
);

	// saved enable, copied at a trap
	logic csr_mpie;
	logic wr_mtvec;
	logic wr_mepc;
	logic wr_sepc;
	logic wr_mie;

	// write strobes per register
	assign wr_mtvec = csr_wr & (csr_wr_sel == CSR_SEL_MTVEC);
	assign wr_mepc = csr_wr & (csr_wr_sel == CSR_SEL_MEPC);
	assign wr_sepc = csr_wr & (csr_wr_sel == CSR_SEL_SEPC);
	assign wr_mie = csr_wr & (csr_wr_sel == CSR_SEL_MIE);

	// trap vector, software only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csr_mtvec <= '0;
		end else if (wr_mtvec) begin
			csr_mtvec <= csr_wr_data;
		end
	end

	// machine return address
	// trap capture wins over a write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csr_mepc <= '0;
		end else if (trap_take) begin
			csr_mepc <= pc_excep;
		end else if (wr_mepc) begin
			csr_mepc <= csr_wr_data;
		end
	end

	// supervisor return address
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csr_sepc <= '0;
		end else if (wr_sepc) begin
			csr_sepc <= csr_wr_data;
		end
	end

	// enable and its saved copy
	// zero after reset, interrupts off until written
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csr_rmie <= 1'b0;
			csr_mpie <= 1'b0;
		end else if (trap_take) begin
			csr_mpie <= csr_rmie;
			csr_rmie <= 1'b0;
		end else if (mret_take) begin
			csr_rmie <= csr_mpie;
		end else if (wr_mie) begin
			csr_rmie <= csr_wr_data[0];
		end
	end

	// pc_stage never raises both in one pc state
	a_take_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(trap_take && mret_take));

endmodule

/* design/pc_stage.sv */
`timescale 1ns/100ps

module pc_stage
	import pc_trap_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             cpu_start,
	input  logic             stall,
	input  logic             cpu_stat_pc,
	input  logic             csr_rmie,
	input  logic             ecall_condition_ex,
	input  logic             g_interrupt,
	input  logic             g_interrupt_1shot,
	input  logic             g_exception,
	input  logic             frc_cntr_val_leq,
	input  logic             jmp_condition_ex,
	input  logic             cmd_mret_ex,
	input  logic             cmd_sret_ex,
	input  logic [ADR_W-1:0] cpu_start_adr,
	input  logic [ADR_W-1:0] csr_mtvec_ex,
	input  logic [ADR_W-1:0] csr_mepc_ex,
	input  logic [ADR_W-1:0] csr_sepc_ex,
	input  logic [ADR_W-1:0] jmp_adr_ex,
	output logic             interrupts_in_pc_state,
	output logic             trap_take,
	output logic             mret_take,
	output logic [ADR_W-1:0] pc,
	output logic [ADR_W-1:0] pc_excep
);

	// pending requests, cleared at the next pc state
	logic             g_interrupt_latch;
	logic             frc_leq_latch;
	// compare level one cycle back, for the rising edge
	logic             frc_leq_d;
	logic             frc_leq_1shot;
	// start address still to be loaded
	logic             cpu_adr_ld;
	logic             interrupt_mskd;
	logic             trap_cond;
	logic             pure_ecall;
	logic [ADR_W-1:0] pc_p1;
	logic [ADR_W-1:0] pc_ecall;
	logic [ADR_W-1:0] pc_nxt;

	assign pc_p1 = pc + ADR_W'(1);

	// enabled interrupts, exceptions bypass the enable
	assign interrupt_mskd = (g_interrupt_latch | frc_leq_latch) & csr_rmie;
	assign trap_cond = ecall_condition_ex | interrupt_mskd | g_exception;
	assign interrupts_in_pc_state = interrupt_mskd & cpu_stat_pc;

	// start load beats everything, trap beats the returns
	assign trap_take = cpu_stat_pc & ~cpu_adr_ld & trap_cond;
	assign mret_take = cpu_stat_pc & ~cpu_adr_ld & ~trap_cond & cmd_mret_ex;

	// armed by start, used up by the first pc state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cpu_adr_ld <= 1'b0;
		end else if (cpu_stat_pc) begin
			cpu_adr_ld <= 1'b0;
		end else if (cpu_start) begin
			cpu_adr_ld <= 1'b1;
		end
	end

	// next word address
	always_comb begin
		if (cpu_adr_ld) begin
			pc_nxt = cpu_start_adr;
		end else if (trap_cond) begin
			pc_nxt = csr_mtvec_ex;
		end else if (cmd_mret_ex) begin
			pc_nxt = csr_mepc_ex;
		end else if (cmd_sret_ex) begin
			pc_nxt = csr_sepc_ex;
		end else if (jmp_condition_ex) begin
			pc_nxt = jmp_adr_ex;
		end else begin
			pc_nxt = pc_p1;
		end
	end

	// conditions are stable over the instruction, so taken at its last cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (cpu_stat_pc) begin
			pc <= pc_nxt;
		end
	end

	// ecall return, instruction after the ecall
	always_ff @(posedge clk) begin
		if (ecall_condition_ex) begin
			pc_ecall <= pc_p1;
		end
	end

	// an ecall with an interrupt level pending is treated as the interrupt
	assign pure_ecall = ecall_condition_ex & ~g_interrupt & ~frc_cntr_val_leq;

	assign pc_excep = pure_ecall ? pc_ecall :
		g_exception ? pc :
		jmp_condition_ex ? jmp_adr_ex : pc_p1;

	// external request, only when enabled at arrival
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			g_interrupt_latch <= 1'b0;
		end else if (g_interrupt_1shot & csr_rmie) begin
			g_interrupt_latch <= 1'b1;
		end else if (cpu_stat_pc) begin
			g_interrupt_latch <= 1'b0;
		end
	end

	// timer compare edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frc_leq_d <= 1'b0;
		end else begin
			frc_leq_d <= frc_cntr_val_leq;
		end
	end

	assign frc_leq_1shot = frc_cntr_val_leq & ~frc_leq_d;

	// a high level that stays high is taken only once
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frc_leq_latch <= 1'b0;
		end else if (frc_leq_1shot) begin
			frc_leq_latch <= 1'b1;
		end else if (cpu_stat_pc) begin
			frc_leq_latch <= 1'b0;
		end
	end

	// pc only moves on the edge closing a pc state
	a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!cpu_stat_pc |=> $stable(pc));

endmodule

/* design/cpu_state_seq.sv */
`timescale 1ns/100ps

module cpu_state_seq
	import pc_trap_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       cpu_start,
	input  logic       stall,
	output logic       cpu_stat_pc,
	output logic [2:0] cpu_state
);

	logic [2:0]        state_nxt;
	// one flag per state, exactly one set
	logic [ST_NUM-1:0] st_dec;

	always_comb begin
		state_nxt = cpu_state;
		case (cpu_state)
			ST_IDLE: begin
				if (cpu_start) begin
					state_nxt = ST_PC;
				end
			end
			ST_PC: state_nxt = ST_IF;
			// stall only ever holds the fetch
			ST_IF: begin
				if (!stall) begin
					state_nxt = ST_EX;
				end
			end
			ST_EX: state_nxt = ST_WB;
			// back to pc, next instruction
			ST_WB: state_nxt = ST_PC;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cpu_state <= ST_IDLE;
		end else begin
			cpu_state <= state_nxt;
		end
	end

	// state decode
	always_comb begin
		st_dec = '0;
		st_dec[ST_BIT_IDLE] = (cpu_state == ST_IDLE);
		st_dec[ST_BIT_PC] = (cpu_state == ST_PC);
		st_dec[ST_BIT_IF] = (cpu_state == ST_IF);
		st_dec[ST_BIT_EX] = (cpu_state == ST_EX);
		st_dec[ST_BIT_WB] = (cpu_state == ST_WB);
	end

	// one cycle per instruction
	assign cpu_stat_pc = st_dec[ST_BIT_PC];

	// never an unused code
	a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(st_dec));

	// pc strobe always drops after one cycle
	a_stat_pc_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_stat_pc |=> !cpu_stat_pc);

endmodule

/* design/pc_trap_pkg.sv */
package pc_trap_pkg;

	// word address, bits 31 to 2 of the byte address
	localparam int ADR_W = 30;

	// free running counter and compare value
	localparam int FRC_W = 16;

	// csr write select
	localparam logic [1:0] CSR_SEL_MTVEC = 2'd0;
	localparam logic [1:0] CSR_SEL_MEPC = 2'd1;
	localparam logic [1:0] CSR_SEL_SEPC = 2'd2;
	// interrupt enable, bit 0 of the write data
	localparam logic [1:0] CSR_SEL_MIE = 2'd3;

	// instruction sequencer states
	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_PC = 3'd1;
	localparam logic [2:0] ST_IF = 3'd2;
	localparam logic [2:0] ST_EX = 3'd3;
	localparam logic [2:0] ST_WB = 3'd4;

	// decoded state vector positions
	localparam int ST_BIT_IDLE = 0;
	localparam int ST_BIT_PC = 1;
	localparam int ST_BIT_IF = 2;
	localparam int ST_BIT_EX = 3;
	localparam int ST_BIT_WB = 4;
	localparam int ST_NUM = 5;

endpackage
